//--- source/csr_unit_defines.svh
`ifndef CSR_UNIT_DEFINES_SVH
`define CSR_UNIT_DEFINES_SVH

// ------------------------------
// Widths
// Data path is one RV32 word
`define XLEN                  32
// CSR number as carried on adr
`define CSR_ADDR_W            12

// ------------------------------
// WARL write masks
// mie, mpie and the mpp field
`define MSTATUS_WMASK         32'h0000_1888
// mpp is hardwired to machine mode
`define MSTATUS_MPP_M         2'd3
// msie, mtie and meie only
`define MIE_WMASK             32'h0000_0888
// Mode bit 1 reads as zero, only direct and vectored modes
`define MTVEC_WMASK           32'hFFFF_FFFD
// No compressed ISA, so epc is word aligned
`define MEPC_WMASK            32'hFFFF_FFFC
// cy, tm and ir enables
`define MCOUNTEREN_WMASK      32'h0000_0007
// cy and ir inhibits, tm has no inhibit
`define MCOUNTINHIBIT_WMASK   32'h0000_0005

// ------------------------------
// Constant and ID registers
// MXL 1 with the I, M and U letters
`define MISA_VALUE            32'h4010_1100
`define MVENDORID_VALUE       32'h0000_0000
`define MARCHID_VALUE         32'h0000_0023
`define MIMPID_VALUE          32'h0000_0101
`define MHARTID_VALUE         32'h0000_0000

`endif

//--- source/csr_pkg.sv
`include "csr_unit_defines.svh"

package csr_pkg;

   // ------------------------------
   // Privilege levels, encoded as in the spec
   typedef enum logic [1:0]
   {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_mode_e;

   // ------------------------------
   // CSR numbers kept by this unit
   typedef enum logic [`CSR_ADDR_W-1:0]
   {
      // Machine trap setup
      CSR_MSTATUS       = 12'h300,
      CSR_MISA          = 12'h301,
      CSR_MIE           = 12'h304,
      CSR_MTVEC         = 12'h305,
      CSR_MCOUNTEREN    = 12'h306,
      CSR_MCOUNTINHIBIT = 12'h320,
      // Machine trap handling
      CSR_MSCRATCH      = 12'h340,
      CSR_MEPC          = 12'h341,
      CSR_MCAUSE        = 12'h342,
      CSR_MTVAL         = 12'h343,
      CSR_MIP           = 12'h344,
      // Machine counters, low and high halves
      CSR_MCYCLE        = 12'hB00,
      CSR_MINSTRET      = 12'hB02,
      CSR_MCYCLEH       = 12'hB80,
      CSR_MINSTRETH     = 12'hB82,
      // Unprivileged counter window, read only
      CSR_CYCLE         = 12'hC00,
      CSR_TIME          = 12'hC01,
      CSR_INSTRET       = 12'hC02,
      CSR_CYCLEH        = 12'hC80,
      CSR_TIMEH         = 12'hC81,
      CSR_INSTRETH      = 12'hC82,
      // Machine information, read only
      CSR_MVENDORID     = 12'hF11,
      CSR_MARCHID       = 12'hF12,
      CSR_MIMPID        = 12'hF13,
      CSR_MHARTID       = 12'hF14
   } csr_addr_e;

endpackage

//--- source/csr_wb_slave.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_wb_slave
   import csr_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Wishbone classic slave
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`CSR_ADDR_W-1:0] adr,
   input  logic [`XLEN-1:0]       dat_w,
   output logic [`XLEN-1:0]       dat_r,
   output logic                   ack,
   output logic                   err,
   // Read decode
   output csr_addr_e              rd_addr,
   input  logic [`XLEN-1:0]       rd_data,
   input  logic                   exists,
   input  logic                   avail,
   input  logic                   writable,
   // Write strobe to storage
   output logic                   wr_en,
   output csr_addr_e              wr_addr,
   output logic [`XLEN-1:0]       wr_data
);

   logic access;
   logic grant;

   // ------------------------------
   // New cycle only when no response is still on the bus
   assign access = cyc && stb && !(ack || err);

   // Register must exist, be readable in this mode, and take writes if asked to
   assign grant = exists && avail && (!we || writable);

   // CSR number goes straight to the decoder
   assign rd_addr = csr_addr_e'(adr);
   assign wr_addr = csr_addr_e'(adr);
   assign wr_data = dat_w;

   // Storage updates on the same edge that registers ack
   assign wr_en = access && we && grant;

   // ------------------------------
   // Response, exactly one of ack or err for one cycle
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         ack <= 1'b0;
         err <= 1'b0;
      end
      else
      begin
         ack <= access && grant;
         err <= access && !grant;
      end
   end

   // Read data captured alongside ack
   always_ff @(posedge clk)
   begin
      if (access && !we && grant)
         dat_r <= rd_data;
   end

endmodule

//--- source/csr_machine_regs.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_machine_regs
   import csr_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,
   // Write strobe from the bus slave
   input  logic             wr_en,
   input  csr_addr_e        wr_addr,
   input  logic [`XLEN-1:0] wr_data,
   // Register values
   output logic [`XLEN-1:0] mstatus,
   output logic [`XLEN-1:0] mie,
   output logic [`XLEN-1:0] mtvec,
   output logic [`XLEN-1:0] mcounteren,
   output logic [`XLEN-1:0] mcountinhibit,
   output logic [`XLEN-1:0] mscratch,
   output logic [`XLEN-1:0] mepc,
   output logic [`XLEN-1:0] mcause,
   output logic [`XLEN-1:0] mtval
);

   // Stored mstatus bits, mpp is merged on the way out
   logic [`XLEN-1:0] mstatus_q;

   // ------------------------------
   // Trap registers, each masked to its legal bits
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mstatus_q     <= '0;
         mie           <= '0;
         mtvec         <= '0;
         mcounteren    <= '0;
         mcountinhibit <= '0;
         mscratch      <= '0;
         mepc          <= '0;
         mcause        <= '0;
         mtval         <= '0;
      end
      else if (wr_en)
      begin
         case (wr_addr)
            // Only mie, mpie and mpp land here
            CSR_MSTATUS:       mstatus_q     <= wr_data & `MSTATUS_WMASK;
            CSR_MIE:           mie           <= wr_data & `MIE_WMASK;
            // Base plus mode, bit 1 dropped
            CSR_MTVEC:         mtvec         <= wr_data & `MTVEC_WMASK;
            CSR_MCOUNTEREN:    mcounteren    <= wr_data & `MCOUNTEREN_WMASK;
            CSR_MCOUNTINHIBIT: mcountinhibit <= wr_data & `MCOUNTINHIBIT_WMASK;
            // Scratch, cause and tval take any value
            CSR_MSCRATCH:      mscratch      <= wr_data;
            CSR_MEPC:          mepc          <= wr_data & `MEPC_WMASK;
            CSR_MCAUSE:        mcause        <= wr_data;
            CSR_MTVAL:         mtval         <= wr_data;
            // Counters and read-only numbers are not ours
            default:
            begin
            end
         endcase
      end
   end

   // ------------------------------
   // Only machine mode exists below it as a trap target
   // OR of the fixed field makes mpp always read 3
   assign mstatus = mstatus_q | {19'b0, `MSTATUS_MPP_M, 11'b0};

endmodule

//--- source/csr_counters.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_counters
   import csr_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   // Write strobe from the bus slave
   input  logic               wr_en,
   input  csr_addr_e          wr_addr,
   input  logic [`XLEN-1:0]   wr_data,
   // Count control
   input  logic [`XLEN-1:0]   mcountinhibit,
   input  logic               retire,
   // 64-bit counter values
   output logic [2*`XLEN-1:0] mcycle,
   output logic [2*`XLEN-1:0] minstret
);

   logic cycle_inc;
   logic instret_inc;
   logic ld_cycle_lo;
   logic ld_cycle_hi;
   logic ld_instret_lo;
   logic ld_instret_hi;

   // ------------------------------
   // Next value for one counter
   // A software load wins over the increment for that cycle
   function automatic logic [2*`XLEN-1:0] next_count
   (
      input logic [2*`XLEN-1:0] cur,
      input logic               inc,
      input logic               ld_lo,
      input logic               ld_hi,
      input logic [`XLEN-1:0]   data
   );
      logic [2*`XLEN-1:0] nxt;
      nxt = cur;
      if (ld_lo)
         nxt = {cur[2*`XLEN-1:`XLEN], data};
      else if (ld_hi)
         nxt = {data, cur[`XLEN-1:0]};
      else if (inc)
         nxt = cur + 1'b1;
      return nxt;
   endfunction

   // cy inhibit is bit 0, ir inhibit is bit 2
   assign cycle_inc   = !mcountinhibit[0];
   assign instret_inc = retire && !mcountinhibit[2];

   // Half decode of the machine counter numbers
   assign ld_cycle_lo   = wr_en && (wr_addr == CSR_MCYCLE);
   assign ld_cycle_hi   = wr_en && (wr_addr == CSR_MCYCLEH);
   assign ld_instret_lo = wr_en && (wr_addr == CSR_MINSTRET);
   assign ld_instret_hi = wr_en && (wr_addr == CSR_MINSTRETH);

   // ------------------------------
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         mcycle   <= '0;
         minstret <= '0;
      end
      else
      begin
         mcycle   <= next_count(mcycle, cycle_inc, ld_cycle_lo, ld_cycle_hi, wr_data);
         minstret <= next_count(minstret, instret_inc, ld_instret_lo, ld_instret_hi,
                                wr_data);
      end
   end

endmodule

//--- source/csr_read_mux.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_read_mux
   import csr_pkg::*;
(
   input  csr_addr_e          rd_addr,
   input  priv_mode_e         mode,
   // Machine trap registers
   input  logic [`XLEN-1:0]   mstatus,
   input  logic [`XLEN-1:0]   mie,
   input  logic [`XLEN-1:0]   mtvec,
   input  logic [`XLEN-1:0]   mcounteren,
   input  logic [`XLEN-1:0]   mcountinhibit,
   input  logic [`XLEN-1:0]   mscratch,
   input  logic [`XLEN-1:0]   mepc,
   input  logic [`XLEN-1:0]   mcause,
   input  logic [`XLEN-1:0]   mtval,
   // Counters and platform timer
   input  logic [2*`XLEN-1:0] mcycle,
   input  logic [2*`XLEN-1:0] minstret,
   input  logic [2*`XLEN-1:0] mtime,
   // Interrupt lines
   input  logic               meip,
   input  logic               mtip,
   input  logic               msip,
   // Decode results
   output logic [`XLEN-1:0]   rd_data,
   output logic               exists,
   output logic               avail,
   output logic               writable
);

   logic [`XLEN-1:0] mip;
   logic             cntr_window;

   // Pending bits follow the lines directly
   assign mip = {20'b0, meip, 3'b0, mtip, 3'b0, msip, 3'b0};

   // ------------------------------
   // Data select and existence
   always_comb
   begin
      exists  = 1'b1;
      rd_data = '0;
      case (rd_addr)
         CSR_MSTATUS:       rd_data = mstatus;
         CSR_MISA:          rd_data = `MISA_VALUE;
         CSR_MIE:           rd_data = mie;
         CSR_MTVEC:         rd_data = mtvec;
         CSR_MCOUNTEREN:    rd_data = mcounteren;
         CSR_MCOUNTINHIBIT: rd_data = mcountinhibit;
         CSR_MSCRATCH:      rd_data = mscratch;
         CSR_MEPC:          rd_data = mepc;
         CSR_MCAUSE:        rd_data = mcause;
         CSR_MTVAL:         rd_data = mtval;
         CSR_MIP:           rd_data = mip;
         // Machine and user views share the same counters
         CSR_MCYCLE,    CSR_CYCLE:    rd_data = mcycle[`XLEN-1:0];
         CSR_MCYCLEH,   CSR_CYCLEH:   rd_data = mcycle[2*`XLEN-1:`XLEN];
         CSR_MINSTRET,  CSR_INSTRET:  rd_data = minstret[`XLEN-1:0];
         CSR_MINSTRETH, CSR_INSTRETH: rd_data = minstret[2*`XLEN-1:`XLEN];
         CSR_TIME:          rd_data = mtime[`XLEN-1:0];
         CSR_TIMEH:         rd_data = mtime[2*`XLEN-1:`XLEN];
         CSR_MVENDORID:     rd_data = `MVENDORID_VALUE;
         CSR_MARCHID:       rd_data = `MARCHID_VALUE;
         CSR_MIMPID:        rd_data = `MIMPID_VALUE;
         CSR_MHARTID:       rd_data = `MHARTID_VALUE;
         default:           exists  = 1'b0;
      endcase
   end

   // ------------------------------
   // Top two number bits 11 mark the read-only space
   // misa and mip sit in read-write space but take no writes here
   assign writable = exists && (rd_addr[11:10] != 2'b11)
                     && (rd_addr != CSR_MISA) && (rd_addr != CSR_MIP);

   // C00 window, gated by mcounteren below machine mode
   assign cntr_window = (rd_addr[11:8] == 4'hC);

   // Low five number bits pick the enable bit
   assign avail = !cntr_window || (mode == PRIV_M) || mcounteren[rd_addr[4:0]];

endmodule

//--- source/csr_unit_top.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_unit_top
   import csr_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // Wishbone classic slave
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`CSR_ADDR_W-1:0] adr,
   input  logic [`XLEN-1:0]       dat_w,
   output logic [`XLEN-1:0]       dat_r,
   output logic                   ack,
   output logic                   err,
   // Core side
   input  priv_mode_e             mode,
   input  logic                   retire,
   input  logic [2*`XLEN-1:0]     mtime,
   input  logic                   meip,
   input  logic                   mtip,
   input  logic                   msip
);

   // ------------------------------
   // Read path, decoded from the live bus address
   csr_addr_e            rd_addr;
   logic [`XLEN-1:0]     rd_data;
   logic                 exists;
   logic                 avail;
   logic                 writable;

   // Write strobe shared by both storage blocks
   logic                 wr_en;
   csr_addr_e            wr_addr;
   logic [`XLEN-1:0]     wr_data;

   // Register values into the read mux
   logic [`XLEN-1:0]     mstatus;
   logic [`XLEN-1:0]     mie;
   logic [`XLEN-1:0]     mtvec;
   logic [`XLEN-1:0]     mcounteren;
   logic [`XLEN-1:0]     mcountinhibit;
   logic [`XLEN-1:0]     mscratch;
   logic [`XLEN-1:0]     mepc;
   logic [`XLEN-1:0]     mcause;
   logic [`XLEN-1:0]     mtval;
   logic [2*`XLEN-1:0]   mcycle;
   logic [2*`XLEN-1:0]   minstret;

   // ------------------------------
   csr_wb_slave i_wb_slave
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .cyc      (cyc),
      .stb      (stb),
      .we       (we),
      .adr      (adr),
      .dat_w    (dat_w),
      .dat_r    (dat_r),
      .ack      (ack),
      .err      (err),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data),
      .exists   (exists),
      .avail    (avail),
      .writable (writable),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

   csr_machine_regs i_machine_regs
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .mstatus       (mstatus),
      .mie           (mie),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval)
   );

   csr_counters i_counters
   (
      .clk           (clk),
      .rst_n         (rst_n),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .mcountinhibit (mcountinhibit),
      .retire        (retire),
      .mcycle        (mcycle),
      .minstret      (minstret)
   );

   csr_read_mux i_read_mux
   (
      .rd_addr       (rd_addr),
      .mode          (mode),
      .mstatus       (mstatus),
      .mie           (mie),
      .mtvec         (mtvec),
      .mcounteren    (mcounteren),
      .mcountinhibit (mcountinhibit),
      .mscratch      (mscratch),
      .mepc          (mepc),
      .mcause        (mcause),
      .mtval         (mtval),
      .mcycle        (mcycle),
      .minstret      (minstret),
      .mtime         (mtime),
      .meip          (meip),
      .mtip          (mtip),
      .msip          (msip),
      .rd_data       (rd_data),
      .exists        (exists),
      .avail         (avail),
      .writable      (writable)
   );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic rst_n
);

   // 100 ns period
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Reset held over 8 rising edges, released on a falling edge
   initial
   begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

//--- tests/csr_unit_assert.sv
`timescale 1ns/1ps

module csr_unit_assert
(
   input logic clk,
   input logic rst_n,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic err
);

   // Number of failed protocol checks
   int fail_count = 0;

   // ------------------------------
   // Never both responses at once
   a_one_resp : assert property (@(posedge clk) disable iff (!rst_n) !(ack && err))
   else
   begin
      fail_count++;
      $error("ack and err high in the same cycle");
   end

   // Response lasts a single cycle
   a_resp_pulse : assert property (@(posedge clk) disable iff (!rst_n)
                                   (ack || err) |=> !(ack || err))
   else
   begin
      fail_count++;
      $error("Response held for more than one cycle");
   end

   // Response only follows a sampled strobe
   a_resp_cause : assert property (@(posedge clk) disable iff (!rst_n)
                                   (ack || err) |-> $past(cyc && stb))
   else
   begin
      fail_count++;
      $error("Response without cyc and stb in the cycle before");
   end

endmodule

bind csr_unit_top csr_unit_assert i_assert
(
   .clk   (clk),
   .rst_n (rst_n),
   .cyc   (cyc),
   .stb   (stb),
   .ack   (ack),
   .err   (err)
);

//--- tests/csr_unit_tb.sv
`timescale 1ns/1ps

`include "csr_unit_defines.svh"

module csr_unit_tb
   import csr_pkg::*;
();

   // ------------------------------
   // Run length
   localparam int NUM_RAND     = 400;
   // Trap pairs, counter block, read-only block, mip sweep, window sweep
   localparam int NUM_DIRECTED = 9 * 2 + 18 + 17 + 8 + 2 * 4 * 7;
   // Each access is one bus cycle and one idle cycle
   localparam int TEST_CYCLES  = 8 + 2 * (NUM_RAND + NUM_DIRECTED);
   localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;
   // mpp sits at bits 12:11 and always reads machine mode
   localparam logic [31:0] MPP_FIELD = 32'(`MSTATUS_MPP_M) << 11;

   logic                   clk;
   logic                   rst_n;
   logic                   cyc;
   logic                   stb;
   logic                   we;
   logic [`CSR_ADDR_W-1:0] adr;
   logic [`XLEN-1:0]       dat_w;
   logic [`XLEN-1:0]       dat_r;
   logic                   ack;
   logic                   err;
   priv_mode_e             mode;
   logic                   retire;
   logic [2*`XLEN-1:0]     mtime;
   logic                   meip;
   logic                   mtip;
   logic                   msip;

   // Reference model state
   logic [`XLEN-1:0]   m_mstatus;
   logic [`XLEN-1:0]   m_mie;
   logic [`XLEN-1:0]   m_mtvec;
   logic [`XLEN-1:0]   m_mcounteren;
   logic [`XLEN-1:0]   m_minhibit;
   logic [`XLEN-1:0]   m_mscratch;
   logic [`XLEN-1:0]   m_mepc;
   logic [`XLEN-1:0]   m_mcause;
   logic [`XLEN-1:0]   m_mtval;
   logic [2*`XLEN-1:0] m_mcycle;
   logic [2*`XLEN-1:0] m_minstret;
   logic [31:0]        rng;

   // CSR numbers the unit keeps, then numbers it does not
   logic [11:0] kept_addrs [0:24] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h306,
      12'h320, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344, 12'hB00, 12'hB02, 12'hB80,
      12'hB82, 12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82, 12'hF11, 12'hF12,
      12'hF13, 12'hF14};
   logic [11:0] spare_addrs [0:6] = '{12'h000, 12'h302, 12'h7B0, 12'hB03, 12'hC03,
      12'hF15, 12'hFFF};
   logic [11:0] trap_addrs [0:8] = '{12'h300, 12'h304, 12'h305, 12'h306, 12'h320,
      12'h340, 12'h341, 12'h342, 12'h343};
   logic [11:0] cnt_addrs [0:3] = '{12'hB00, 12'hB80, 12'hB02, 12'hB82};
   // First five are also read back
   logic [11:0] ro_addrs [0:11] = '{12'h301, 12'hF11, 12'hF12, 12'hF13, 12'hF14,
      12'h344, 12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82};
   logic [11:0] win_addrs [0:5] = '{12'hC00, 12'hC01, 12'hC02, 12'hC80, 12'hC81, 12'hC82};

   tb_clock_gen i_clock_gen
   (
      .clk   (clk),
      .rst_n (rst_n)
   );

   csr_unit_top i_dut
   (
      .clk    (clk),
      .rst_n  (rst_n),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .dat_w  (dat_w),
      .dat_r  (dat_r),
      .ack    (ack),
      .err    (err),
      .mode   (mode),
      .retire (retire),
      .mtime  (mtime),
      .meip   (meip),
      .mtip   (mtip),
      .msip   (msip)
   );

   // ------------------------------
   // Random numbers
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   // ------------------------------
   // Compare tasks
   task automatic check_data(input csr_addr_e a, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("Fail dat_r addr 0x%03h got 0x%08h exp 0x%08h", a, got, exp));
   endtask

   task automatic check_resp(input csr_addr_e a, input logic got_ack, input logic got_err,
                             input logic exp_ack);
      // Neither or both high means the one-cycle handshake broke
      if (got_ack === got_err)
         abort_run($sformatf("No single response one cycle after access to CSR 0x%03h", a));
      else if (got_ack !== exp_ack)
         abort_run($sformatf("Fail ack addr 0x%03h got 0x%0h exp 0x%0h", a, got_ack, exp_ack));
   endtask

   task automatic check_mode_gate(input priv_mode_e m, input csr_addr_e a,
                                  input logic got_avail, input logic exp_avail);
      if (got_avail !== exp_avail)
         abort_run($sformatf("Fail avail mode 0x%0h addr 0x%03h got 0x%0h exp 0x%0h",
                             m, a, got_avail, exp_avail));
   endtask

   // ------------------------------
   // Model lookups
   function automatic logic model_writable(input logic [11:0] a);
      case (a)
         12'h300, 12'h304, 12'h305, 12'h306, 12'h320: return 1'b1;
         12'h340, 12'h341, 12'h342, 12'h343:          return 1'b1;
         12'hB00, 12'hB02, 12'hB80, 12'hB82:          return 1'b1;
         default:                                     return 1'b0;
      endcase
   endfunction

   function automatic logic model_grant(input logic w, input logic [11:0] a);
      logic known;
      logic readable;
      known = 1'b0;
      foreach (kept_addrs[i])
         if (kept_addrs[i] == a)
            known = 1'b1;
      // Counter window below machine mode needs its mcounteren bit
      readable = (a[11:8] != 4'hC) || (mode == PRIV_M) || m_mcounteren[a[4:0]];
      return known && readable && (!w || model_writable(a));
   endfunction

   function automatic logic [`XLEN-1:0] model_value(input logic [11:0] a);
      case (a)
         12'h300:          return m_mstatus;
         12'h301:          return `MISA_VALUE;
         12'h304:          return m_mie;
         12'h305:          return m_mtvec;
         12'h306:          return m_mcounteren;
         12'h320:          return m_minhibit;
         12'h340:          return m_mscratch;
         12'h341:          return m_mepc;
         12'h342:          return m_mcause;
         12'h343:          return m_mtval;
         // meip at 11, mtip at 7, msip at 3
         12'h344:          return (32'(meip) << 11) | (32'(mtip) << 7) | (32'(msip) << 3);
         12'hB00, 12'hC00: return m_mcycle[31:0];
         12'hB80, 12'hC80: return m_mcycle[63:32];
         12'hB02, 12'hC02: return m_minstret[31:0];
         12'hB82, 12'hC82: return m_minstret[63:32];
         12'hC01:          return mtime[31:0];
         12'hC81:          return mtime[63:32];
         12'hF11:          return `MVENDORID_VALUE;
         12'hF12:          return `MARCHID_VALUE;
         12'hF13:          return `MIMPID_VALUE;
         12'hF14:          return `MHARTID_VALUE;
         default:          return '0;
      endcase
   endfunction

   task automatic model_write(input logic [11:0] a, input logic [`XLEN-1:0] d);
      case (a)
         12'h300: m_mstatus         = (d & `MSTATUS_WMASK) | MPP_FIELD;
         12'h304: m_mie             = d & `MIE_WMASK;
         12'h305: m_mtvec           = d & `MTVEC_WMASK;
         12'h306: m_mcounteren      = d & `MCOUNTEREN_WMASK;
         12'h320: m_minhibit        = d & `MCOUNTINHIBIT_WMASK;
         12'h340: m_mscratch        = d;
         12'h341: m_mepc            = d & `MEPC_WMASK;
         12'h342: m_mcause          = d;
         12'h343: m_mtval           = d;
         12'hB00: m_mcycle[31:0]    = d;
         12'hB80: m_mcycle[63:32]   = d;
         12'hB02: m_minstret[31:0]  = d;
         12'hB82: m_minstret[63:32] = d;
         default:
         begin
         end
      endcase
   endtask

   // ------------------------------
   // Model the next rising edge, then move to the falling edge after it
   task automatic clock_edge(input logic wr, input logic [11:0] a, input logic [`XLEN-1:0] d);
      logic [31:0] r;
      logic        cy_load;
      logic        ir_load;
      r       = next_rand();
      retire  = r[0];
      cy_load = wr && (a == 12'hB00 || a == 12'hB80);
      ir_load = wr && (a == 12'hB02 || a == 12'hB82);
      // A load replaces the count, inhibit is the value before this edge
      if (!cy_load && !m_minhibit[0])
         m_mcycle = m_mcycle + 1;
      if (!ir_load && retire && !m_minhibit[2])
         m_minstret = m_minstret + 1;
      if (wr)
         model_write(a, d);
      @(negedge clk);
   endtask

   // One Wishbone access followed by one idle cycle
   task automatic bus_access(input logic w, input logic [11:0] a, input logic [`XLEN-1:0] d,
                             output logic [`XLEN-1:0] rdata, output logic got_ack);
      logic             exp_ok;
      logic [`XLEN-1:0] exp_data;
      cyc      = 1'b1;
      stb      = 1'b1;
      we       = w;
      adr      = a;
      dat_w    = d;
      exp_ok   = model_grant(w, a);
      exp_data = model_value(a);
      clock_edge(w && exp_ok, a, d);
      check_resp(csr_addr_e'(a), ack, err, exp_ok);
      if (!w && exp_ok)
         check_data(csr_addr_e'(a), dat_r, exp_data);
      rdata   = dat_r;
      got_ack = ack;
      cyc     = 1'b0;
      stb     = 1'b0;
      clock_edge(1'b0, a, d);
   endtask

   // ------------------------------
   // Watchdog
   initial
   begin
      int cycles;
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      abort_run($sformatf("Timeout after %0d cycles", cycles));
   end

   // ------------------------------
   // Stimulus
   initial
   begin
      logic [`XLEN-1:0] rdata;
      logic [`XLEN-1:0] wdata;
      logic [`XLEN-1:0] cnt_data [0:3];
      logic [31:0]      r;
      logic [11:0]      a;
      logic             got_ack;
      int               fails;
      rng    = 32'h8bd60b88;
      cyc    = 1'b0;
      stb    = 1'b0;
      we     = 1'b0;
      adr    = '0;
      dat_w  = '0;
      mode   = PRIV_M;
      retire = 1'b0;
      mtime  = 64'h0000_0012_3456_789A;
      meip   = 1'b0;
      mtip   = 1'b0;
      msip   = 1'b0;
      // Reset state, only mpp is set
      m_mstatus    = MPP_FIELD;
      m_mie        = '0;
      m_mtvec      = '0;
      m_mcounteren = '0;
      m_minhibit   = '0;
      m_mscratch   = '0;
      m_mepc       = '0;
      m_mcause     = '0;
      m_mtval      = '0;
      m_mcycle     = '0;
      m_minstret   = '0;
      wait (rst_n === 1'b1);

      // Trap registers, write then read back masked
      for (int i = 0; i < 9; i++)
      begin
         wdata = next_rand();
         bus_access(1'b1, trap_addrs[i], wdata, rdata, got_ack);
         bus_access(1'b0, trap_addrs[i], '0, rdata, got_ack);
      end

      // Counters frozen, halves read back exactly
      bus_access(1'b1, 12'h320, 32'hFFFF_FFFF, rdata, got_ack);
      for (int i = 0; i < 4; i++)
      begin
         cnt_data[i] = next_rand();
         bus_access(1'b1, cnt_addrs[i], cnt_data[i], rdata, got_ack);
      end
      for (int i = 0; i < 4; i++)
      begin
         bus_access(1'b0, cnt_addrs[i], '0, rdata, got_ack);
         check_data(csr_addr_e'(cnt_addrs[i]), rdata, cnt_data[i]);
      end
      // Running again, model follows each clock and retire pulse
      bus_access(1'b1, 12'h320, 32'h0, rdata, got_ack);
      for (int i = 0; i < 4; i++)
         bus_access(1'b0, 12'h340, '0, rdata, got_ack);
      for (int i = 0; i < 4; i++)
         bus_access(1'b0, cnt_addrs[i], '0, rdata, got_ack);

      // Constant registers and read-only numbers
      for (int i = 0; i < 5; i++)
         bus_access(1'b0, ro_addrs[i], '0, rdata, got_ack);
      for (int i = 0; i < 12; i++)
         bus_access(1'b1, ro_addrs[i], next_rand(), rdata, got_ack);

      // mip follows the interrupt lines
      for (int i = 0; i < 8; i++)
      begin
         {meip, mtip, msip} = 3'(i);
         bus_access(1'b0, 12'h344, '0, rdata, got_ack);
      end

      // Counter window gated by mcounteren in user and supervisor mode
      for (int k = 0; k < 2; k++)
      begin
         for (int n = 0; n < 4; n++)
         begin
            wdata = next_rand();
            mtime = {next_rand(), next_rand()};
            mode  = PRIV_M;
            bus_access(1'b1, 12'h306, wdata, rdata, got_ack);
            mode = (k == 0) ? PRIV_U : PRIV_S;
            for (int j = 0; j < 6; j++)
            begin
               bus_access(1'b0, win_addrs[j], '0, rdata, got_ack);
               check_mode_gate(mode, csr_addr_e'(win_addrs[j]), got_ack, wdata[j % 3]);
            end
         end
      end

      // Random mix of numbers, modes and data
      for (int i = 0; i < NUM_RAND; i++)
      begin
         r = next_rand();
         a = (r[4:0] < 25) ? kept_addrs[r[4:0]] : spare_addrs[r[4:0] - 25];
         case (r[6:5])
            2'd0:    mode = PRIV_U;
            2'd1:    mode = PRIV_S;
            default: mode = PRIV_M;
         endcase
         {meip, mtip, msip} = r[9:7];
         if (r[12:10] == 3'd0)
            mtime = {next_rand(), next_rand()};
         bus_access(r[13], a, next_rand(), rdata, got_ack);
      end

      fails = i_dut.i_assert.fail_count;
      if (fails == 0)
      begin
         $display("Test passed");
         $finish;
      end
      else
         abort_run($sformatf("Protocol assertions failed %0d times", fails));
   end

endmodule

//--- csr_unit.f
+incdir+source
source/csr_pkg.sv
source/csr_wb_slave.sv
source/csr_machine_regs.sv
source/csr_counters.sv
source/csr_read_mux.sv
source/csr_unit_top.sv
tests/tb_clock_gen.sv
tests/csr_unit_assert.sv
tests/csr_unit_tb.sv
